// File: src/lbPkg.sv
package lbPkg;

    localparam int numPorts = 2;
    localparam int lbEntries = 8;
    localparam int lbIdxW = 3;
    localparam int sqNW = 7;

    // Load number bits above the ring index, stored per entry as its age
    localparam int tagW = sqNW - lbIdxW;

    typedef logic [sqNW-1:0] sqN_t;
    typedef logic [31:0] addr_t;
    typedef logic [1:0] size_t;
    typedef logic [lbIdxW-1:0] lbIdx_t;
    typedef logic [tagW-1:0] tag_t;

    // Sequence numbers wrap, so order is judged by the signed difference
    function automatic logic isOlderOrSame(sqN_t a, sqN_t b);
        sqN_t diff;
        diff = a - b;
        return $signed(diff) <= 0;
    endfunction

    // Both accesses are assumed to lie in the same 32-bit word
    function automatic logic bytesOverlap(addr_t aAddr, size_t aSize,
                                          addr_t bAddr, size_t bSize);
        logic overlap;
        case (aSize)
            2'd0: begin
                overlap = (bSize != 2'd0) || (aAddr[1:0] == bAddr[1:0]);
            end
            2'd1: begin
                overlap = (bSize >= 2'd2) || (aAddr[1] == bAddr[1]);
            end
            default: begin
                overlap = 1'b1;
            end
        endcase
        return overlap;
    endfunction

endpackage

// File: src/loadEntryArray.sv
`timescale 1ns/10ps

module loadEntryArray (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [lbPkg::numPorts-1:0]               uopValid,
    input  logic [lbPkg::numPorts-1:0]               uopIsLoad,
    input  lbPkg::addr_t [lbPkg::numPorts-1:0]       uopAddr,
    input  lbPkg::size_t [lbPkg::numPorts-1:0]       uopSize,
    input  lbPkg::sqN_t [lbPkg::numPorts-1:0]        uopSqN,
    input  lbPkg::sqN_t [lbPkg::numPorts-1:0]        uopLoadSqN,
    input  lbPkg::sqN_t                              comLoadSqN,
    input  logic                                     brTaken,
    input  lbPkg::sqN_t                              brSqN,
    input  lbPkg::sqN_t                              brLoadSqN,
    output logic [lbPkg::lbEntries-1:0]              entValid,
    output lbPkg::addr_t [lbPkg::lbEntries-1:0]      entAddr,
    output lbPkg::size_t [lbPkg::lbEntries-1:0]      entSize,
    output lbPkg::sqN_t [lbPkg::lbEntries-1:0]       entLoadSqN,
    output lbPkg::sqN_t                              maxLoadSqN
);

    import lbPkg::*;

    logic [lbEntries-1:0] entryValid;
    addr_t                entryAddr [lbEntries];
    size_t                entrySize [lbEntries];
    tag_t                 entryTag [lbEntries];

    // Commit pointer of the previous cycle, start of the release range
    sqN_t lastComLoadSqN;

    logic [lbEntries-1:0] ringMask;
    logic [lbEntries-1:0] clearMask;
    logic [numPorts-1:0]  insert;
    sqN_t                 brDist;
    logic                 killInRange;

    // Ring range from the begin index up to, but not including, the commit index
    always_comb begin
        lbIdx_t rangeBegin;
        lbIdx_t rangeEnd;
        logic   active;
        rangeBegin = brTaken ? brLoadSqN[lbIdxW-1:0] : lastComLoadSqN[lbIdxW-1:0];
        rangeEnd = comLoadSqN[lbIdxW-1:0];
        // When both ends meet a kill covers the whole ring and a release covers nothing
        if (brTaken) begin
            active = rangeEnd <= rangeBegin;
        end else begin
            active = rangeEnd < rangeBegin;
        end
        for (int i = 0; i < lbEntries; i++) begin
            if (brTaken) begin
                if (lbIdx_t'(i) == rangeBegin) begin
                    active = 1'b1;
                end else if (lbIdx_t'(i) == rangeEnd) begin
                    active = 1'b0;
                end
            end else begin
                if (lbIdx_t'(i) == rangeEnd) begin
                    active = 1'b0;
                end else if (lbIdx_t'(i) == rangeBegin) begin
                    active = 1'b1;
                end
            end
            ringMask[i] = active;
        end
    end

    // A rollback to a load number beyond the ring leaves every entry alone
    assign brDist = brLoadSqN - comLoadSqN;
    assign killInRange = $signed(brDist) < lbEntries;

    always_comb begin
        if (brTaken && !killInRange) begin
            clearMask = '0;
        end else begin
            clearMask = ringMask;
        end
    end

    // Loads younger than a same-cycle rollback are dropped
    always_comb begin
        for (int p = 0; p < numPorts; p++) begin
            insert[p] = uopValid[p] && uopIsLoad[p] &&
                        (!brTaken || isOlderOrSame(uopSqN[p], brSqN));
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < numPorts; p++) begin
            if (insert[p]) begin
                entryAddr[uopLoadSqN[p][lbIdxW-1:0]] <= uopAddr[p];
                entrySize[uopLoadSqN[p][lbIdxW-1:0]] <= uopSize[p];
                entryTag[uopLoadSqN[p][lbIdxW-1:0]] <= uopLoadSqN[p][sqNW-1:lbIdxW];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            lastComLoadSqN <= '0;
            maxLoadSqN <= sqN_t'(lbEntries - 1);
        end else begin
            entryValid <= entryValid & ~clearMask;
            // Later assignments win, so an insertion overrides a same-cycle clear
            for (int p = 0; p < numPorts; p++) begin
                if (insert[p]) begin
                    entryValid[uopLoadSqN[p][lbIdxW-1:0]] <= 1'b1;
                end
            end
            lastComLoadSqN <= comLoadSqN;
            maxLoadSqN <= comLoadSqN + sqN_t'(lbEntries - 1);
        end
    end

    always_comb begin
        for (int i = 0; i < lbEntries; i++) begin
            entAddr[i] = entryAddr[i];
            entSize[i] = entrySize[i];
            entLoadSqN[i] = {entryTag[i], lbIdx_t'(i)};
        end
    end

    assign entValid = entryValid;

endmodule

// File: src/orderChecker.sv
`timescale 1ns/10ps

module orderChecker (
    input  logic                                  uopValid,
    input  logic                                  uopIsStore,
    input  lbPkg::addr_t                          uopAddr,
    input  lbPkg::size_t                          uopSize,
    input  lbPkg::sqN_t                           uopLoadSqN,
    input  logic [lbPkg::lbEntries-1:0]           entValid,
    input  lbPkg::addr_t [lbPkg::lbEntries-1:0]   entAddr,
    input  lbPkg::size_t [lbPkg::lbEntries-1:0]   entSize,
    input  lbPkg::sqN_t [lbPkg::lbEntries-1:0]    entLoadSqN,
    output logic                                  conflict
);

    import lbPkg::*;

    logic [lbEntries-1:0] sameWord;
    logic [lbEntries-1:0] overlap;
    logic [lbEntries-1:0] younger;
    logic [lbEntries-1:0] hit;

    // A load at or after the store's next load number executed too early
    always_comb begin
        for (int i = 0; i < lbEntries; i++) begin
            sameWord[i] = entAddr[i][31:2] == uopAddr[31:2];
            overlap[i] = bytesOverlap(uopAddr, uopSize, entAddr[i], entSize[i]);
            younger[i] = isOlderOrSame(uopLoadSqN, entLoadSqN[i]);
            hit[i] = entValid[i] && sameWord[i] && overlap[i] && younger[i];
        end
    end

    assign conflict = uopValid && uopIsStore && (|hit);

endmodule

// File: src/rollbackArbiter.sv
`timescale 1ns/10ps

module rollbackArbiter (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [lbPkg::numPorts-1:0]           conflict,
    input  lbPkg::sqN_t [lbPkg::numPorts-1:0]    uopSqN,
    input  lbPkg::sqN_t [lbPkg::numPorts-1:0]    uopLoadSqN,
    input  lbPkg::addr_t [lbPkg::numPorts-1:0]   uopPc,
    input  logic [lbPkg::numPorts-1:0]           uopCompressed,
    input  logic                                 brTaken,
    input  lbPkg::sqN_t                          brSqN,
    output logic                                 rbValid,
    output lbPkg::addr_t                         rbPc,
    output lbPkg::sqN_t                          rbSqN,
    output lbPkg::sqN_t                          rbLoadSqN
);

    import lbPkg::*;

    logic  found;
    addr_t selPc;
    sqN_t  selSqN;
    sqN_t  selLoadSqN;

    // Restart after the oldest conflicting store, since its snapshot is the one available
    always_comb begin
        found = 1'b0;
        selPc = '0;
        selSqN = '0;
        selLoadSqN = '0;
        for (int p = 0; p < numPorts; p++) begin
            if (conflict[p] && (!brTaken || isOlderOrSame(uopSqN[p], brSqN))) begin
                if (!found || !isOlderOrSame(selSqN, uopSqN[p])) begin
                    found = 1'b1;
                    selPc = uopPc[p] + (uopCompressed[p] ? 32'd2 : 32'd4);
                    selSqN = uopSqN[p];
                    selLoadSqN = uopLoadSqN[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            rbPc <= selPc;
            rbSqN <= selSqN;
            rbLoadSqN <= selLoadSqN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rbValid <= 1'b0;
        end else begin
            rbValid <= found;
        end
    end

endmodule

// File: src/loadBuffer.sv
`timescale 1ns/10ps

module loadBuffer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [lbPkg::numPorts-1:0]           uopValid,
    input  logic [lbPkg::numPorts-1:0]           uopIsLoad,
    input  logic [lbPkg::numPorts-1:0]           uopIsStore,
    input  lbPkg::addr_t [lbPkg::numPorts-1:0]   uopAddr,
    input  lbPkg::size_t [lbPkg::numPorts-1:0]   uopSize,
    input  lbPkg::sqN_t [lbPkg::numPorts-1:0]    uopSqN,
    input  lbPkg::sqN_t [lbPkg::numPorts-1:0]    uopLoadSqN,
    input  lbPkg::addr_t [lbPkg::numPorts-1:0]   uopPc,
    input  logic [lbPkg::numPorts-1:0]           uopCompressed,
    input  lbPkg::sqN_t                          comLoadSqN,
    input  logic                                 brTaken,
    input  lbPkg::sqN_t                          brSqN,
    input  lbPkg::sqN_t                          brLoadSqN,
    output logic                                 rbValid,
    output lbPkg::addr_t                         rbPc,
    output lbPkg::sqN_t                          rbSqN,
    output lbPkg::sqN_t                          rbLoadSqN,
    output lbPkg::sqN_t                          maxLoadSqN
);

    import lbPkg::*;

    logic [lbEntries-1:0]  entValid;
    addr_t [lbEntries-1:0] entAddr;
    size_t [lbEntries-1:0] entSize;
    sqN_t [lbEntries-1:0]  entLoadSqN;
    logic [numPorts-1:0]   conflict;

    loadEntryArray i_loadEntryArray (
        .clk        (clk),
        .rst        (rst),
        .uopValid   (uopValid),
        .uopIsLoad  (uopIsLoad),
        .uopAddr    (uopAddr),
        .uopSize    (uopSize),
        .uopSqN     (uopSqN),
        .uopLoadSqN (uopLoadSqN),
        .comLoadSqN (comLoadSqN),
        .brTaken    (brTaken),
        .brSqN      (brSqN),
        .brLoadSqN  (brLoadSqN),
        .entValid   (entValid),
        .entAddr    (entAddr),
        .entSize    (entSize),
        .entLoadSqN (entLoadSqN),
        .maxLoadSqN (maxLoadSqN)
    );

    // Each port's store sees only entries recorded before this cycle
    for (genvar p = 0; p < numPorts; p++) begin : gChecker
        orderChecker i_orderChecker (
            .uopValid   (uopValid[p]),
            .uopIsStore (uopIsStore[p]),
            .uopAddr    (uopAddr[p]),
            .uopSize    (uopSize[p]),
            .uopLoadSqN (uopLoadSqN[p]),
            .entValid   (entValid),
            .entAddr    (entAddr),
            .entSize    (entSize),
            .entLoadSqN (entLoadSqN),
            .conflict   (conflict[p])
        );
    end

    rollbackArbiter i_rollbackArbiter (
        .clk           (clk),
        .rst           (rst),
        .conflict      (conflict),
        .uopSqN        (uopSqN),
        .uopLoadSqN    (uopLoadSqN),
        .uopPc         (uopPc),
        .uopCompressed (uopCompressed),
        .brTaken       (brTaken),
        .brSqN         (brSqN),
        .rbValid       (rbValid),
        .rbPc          (rbPc),
        .rbSqN         (rbSqN),
        .rbLoadSqN     (rbLoadSqN)
    );

endmodule

// File: dv/loadBufferTb.sv
`timescale 1ns/10ps

module loadBufferTb;

    import lbPkg::*;

    localparam int resetCycles = 10;
    localparam int resetTimeout = 20;
    localparam int maxFileLines = 1000;
    localparam int numFields = 23;
    localparam int portFields = 7;

    logic                         clk;
    logic                         rst;
    logic [numPorts-1:0]          uopValid;
    logic [numPorts-1:0]          uopIsLoad;
    logic [numPorts-1:0]          uopIsStore;
    addr_t [numPorts-1:0]         uopAddr;
    size_t [numPorts-1:0]         uopSize;
    sqN_t [numPorts-1:0]          uopSqN;
    sqN_t [numPorts-1:0]          uopLoadSqN;
    addr_t [numPorts-1:0]         uopPc;
    logic [numPorts-1:0]          uopCompressed;
    sqN_t                         comLoadSqN;
    logic                         brTaken;
    sqN_t                         brSqN;
    sqN_t                         brLoadSqN;
    logic                         rbValid;
    addr_t                        rbPc;
    sqN_t                         rbSqN;
    sqN_t                         rbLoadSqN;
    sqN_t                         maxLoadSqN;

    // Fields of the current test line, and the expected outputs of the previous one
    logic [31:0] field [numFields];
    logic [31:0] expValid;
    logic [31:0] expPc;
    logic [31:0] expSqN;
    logic [31:0] expLoadSqN;
    logic [31:0] expMax;
    int          expLine;
    bit          havePrev;
    int          vectorCount;
    int          lineNum;
    int          fd;
    bit          endOfFile;
    string       line;

    loadBuffer i_loadBuffer (
        .clk           (clk),
        .rst           (rst),
        .uopValid      (uopValid),
        .uopIsLoad     (uopIsLoad),
        .uopIsStore    (uopIsStore),
        .uopAddr       (uopAddr),
        .uopSize       (uopSize),
        .uopSqN        (uopSqN),
        .uopLoadSqN    (uopLoadSqN),
        .uopPc         (uopPc),
        .uopCompressed (uopCompressed),
        .comLoadSqN    (comLoadSqN),
        .brTaken       (brTaken),
        .brSqN         (brSqN),
        .brLoadSqN     (brLoadSqN),
        .rbValid       (rbValid),
        .rbPc          (rbPc),
        .rbSqN         (rbSqN),
        .rbLoadSqN     (rbLoadSqN),
        .maxLoadSqN    (maxLoadSqN)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0d ns, test line %0d: %s expected %0h, actual %0h",
                     $time, expLine, name, expected, actual);
            $display("Errors found");
            $fatal(1, "Output mismatch");
        end
    endtask

    // The PC and sequence numbers of a rollback only mean something while rbValid is set
    task automatic checkOutputs();
        checkValue("rbValid", expValid, 32'(rbValid));
        if (expValid != 0) begin
            checkValue("rbPc", expPc, rbPc);
            checkValue("rbSqN", expSqN, 32'(rbSqN));
            checkValue("rbLoadSqN", expLoadSqN, 32'(rbLoadSqN));
        end
        checkValue("maxLoadSqN", expMax, 32'(maxLoadSqN));
    endtask

    task automatic driveIdle();
        uopValid <= '0;
        uopIsLoad <= '0;
        uopIsStore <= '0;
        uopAddr <= '0;
        uopSize <= '0;
        uopSqN <= '0;
        uopLoadSqN <= '0;
        uopPc <= '0;
        uopCompressed <= '0;
        brTaken <= 1'b0;
        brSqN <= '0;
        brLoadSqN <= '0;
    endtask

    // Kind 0 is an idle port, 1 a load and 2 a store
    task automatic applyVector();
        int base;
        for (int p = 0; p < numPorts; p++) begin
            base = p * portFields;
            uopValid[p] <= (field[base] != 0);
            uopIsLoad[p] <= (field[base] == 1);
            uopIsStore[p] <= (field[base] == 2);
            uopAddr[p] <= field[base + 1];
            uopSize[p] <= field[base + 2][1:0];
            uopSqN[p] <= field[base + 3][sqNW-1:0];
            uopLoadSqN[p] <= field[base + 4][sqNW-1:0];
            uopPc[p] <= field[base + 5];
            uopCompressed[p] <= field[base + 6][0];
        end
        comLoadSqN <= field[14][sqNW-1:0];
        brTaken <= field[15][0];
        brSqN <= field[16][sqNW-1:0];
        brLoadSqN <= field[17][sqNW-1:0];
    endtask

    function automatic bit isDataLine(input string text);
        logic [7:0] c;
        bit         data;
        bit         done;
        data = 1'b0;
        done = 1'b0;
        for (int i = 0; i < text.len() && !done; i++) begin
            c = text.getc(i);
            if (c != " " && c != "\t" && c != "\n" && c != "\r") begin
                data = (c != "#");
                done = 1'b1;
            end
        end
        return data;
    endfunction

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (!(rbValid === 1'b0 && maxLoadSqN === sqN_t'(lbEntries - 1))) begin
            if (cycles >= resetTimeout) begin
                abortRun("DUT outputs did not reach their reset values in time");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // A line's outputs are checked in the cycle after its stimulus, while the next is driven
    task automatic runVector();
        int fieldCount;
        fieldCount = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            field[0], field[1], field[2], field[3], field[4], field[5], field[6],
            field[7], field[8], field[9], field[10], field[11], field[12], field[13],
            field[14], field[15], field[16], field[17], field[18], field[19], field[20],
            field[21], field[22]);
        if (fieldCount != numFields) begin
            abortRun($sformatf("Test file line %0d has %0d fields instead of %0d",
                               lineNum, fieldCount, numFields));
        end else begin
            @(posedge clk);
            applyVector();
            if (havePrev) begin
                @(negedge clk);
                checkOutputs();
            end
            expValid = field[18];
            expPc = field[19];
            expSqN = field[20];
            expLoadSqN = field[21];
            expMax = field[22];
            expLine = lineNum;
            havePrev = 1'b1;
            vectorCount++;
        end
    endtask

    initial begin
        rst <= 1'b1;
        comLoadSqN <= '0;
        driveIdle();
        havePrev = 1'b0;
        vectorCount = 0;
        lineNum = 0;
        endOfFile = 1'b0;
        fd = $fopen("dv/lbTests.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the test file dv/lbTests.txt");
        end
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        waitForReset();
        while (!endOfFile) begin
            if (lineNum >= maxFileLines) begin
                abortRun("Test file did not end within the line limit");
            end else if ($fgets(line, fd) == 0) begin
                endOfFile = 1'b1;
            end else begin
                lineNum++;
                if (isDataLine(line)) begin
                    runVector();
                end
            end
        end
        $fclose(fd);
        @(posedge clk);
        driveIdle();
        if (havePrev) begin
            @(negedge clk);
            checkOutputs();
        end
        if (vectorCount > 0) begin
            $display("No errors");
            $finish;
        end else begin
            abortRun("Test file held no test vectors");
        end
    end

endmodule

// File: dv/lbTests.txt
# Per port, p0 then p1: kind addr size sqN loadSqN pc compressed (kind 0 idle, 1 load, 2 store)
# Then comLoadSqN brTaken brSqN brLoadSqN and expected rbValid rbPc rbSqN rbLoadSqN maxLoadSqN
# All values hex, expected outputs apply one cycle after the line's stimulus
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 7
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 7
# Word load at load number 3, then overlapping byte stores, plain and compressed
1 100 2 10 3 0 0  0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 7
2 102 0 0c 2 1000 0  0 0 0 0 0 0 0  0 0 0 0  1 1004 0c 2 7
2 101 0 0d 3 1010 1  0 0 0 0 0 0 0  0 0 0 0  1 1012 0d 3 7
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 7
# Other word, disjoint bytes, and stores whose load number lies after the load
2 104 2 0e 2 1020 0  1 200 0 12 4 0 0  0 0 0 0  0 0 0 0 7
2 201 0 0e 2 1020 0  0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 7
2 200 1 13 5 1030 0  2 100 2 14 4 1040 0  0 0 0 0  0 0 0 0 7
2 200 1 11 4 1050 0  0 0 0 0 0 0 0  0 0 0 0  1 1054 11 4 7
2 202 1 11 4 1060 0  0 0 0 0 0 0 0  0 0 0 0  0 0 0 0 7
# Conflicts on both ports, the older sqN wins, also across the wrap
2 100 2 20 3 2000 0  2 200 0 1c 4 3000 1  0 0 0 0  1 3002 1c 4 7
2 100 2 18 3 2100 1  2 200 0 1a 4 3100 0  0 0 0 0  1 2102 18 3 7
2 100 2 02 3 2200 0  2 200 0 7e 4 3200 0  0 0 0 0  1 3204 7e 4 7
2 100 2 7d 3 2300 0  2 200 0 01 4 3300 0  0 0 0 0  1 2304 7d 3 7
# Commit past load 3
0 0 0 0 0 0 0  0 0 0 0 0 0 0  4 0 0 0  0 0 0 0 b
2 100 2 21 3 2400 0  0 0 0 0 0 0 0  4 0 0 0  0 0 0 0 b
# Rollback kills load 6, a younger store in the rollback cycle is dropped
1 300 2 30 6 0 0  0 0 0 0 0 0 0  4 0 0 0  0 0 0 0 b
0 0 0 0 0 0 0  2 200 0 31 4 4000 0  4 1 2f 6  0 0 0 0 b
2 300 2 28 5 4100 0  0 0 0 0 0 0 0  4 0 0 0  0 0 0 0 b
2 200 0 29 4 4200 1  0 0 0 0 0 0 0  4 0 0 0  1 4202 29 4 b
# An older store in the rollback cycle still conflicts, a younger load is not recorded
2 200 2 3f 4 4300 0  1 500 2 41 5 0 0  4 1 40 5  1 4304 3f 4 b
2 500 2 3e 5 4400 0  0 0 0 0 0 0 0  4 0 0 0  0 0 0 0 b
# An older load in the rollback cycle is recorded over the kill
0 0 0 0 0 0 0  1 600 2 4f 5 0 0  4 1 50 5  0 0 0 0 b
2 600 0 4e 5 4500 0  0 0 0 0 0 0 0  4 0 0 0  1 4504 4e 5 b
# Rollback at load 4 empties the ring
0 0 0 0 0 0 0  0 0 0 0 0 0 0  4 1 60 4  0 0 0 0 b
2 200 0 5a 4 4600 0  2 600 2 5b 5 4700 0  4 0 0 0  0 0 0 0 b
# Commit pointer moves and maxLoadSqN wraps
0 0 0 0 0 0 0  0 0 0 0 0 0 0  5 0 0 0  0 0 0 0 c
0 0 0 0 0 0 0  0 0 0 0 0 0 0  7c 0 0 0  0 0 0 0 3
0 0 0 0 0 0 0  0 0 0 0 0 0 0  7e 0 0 0  0 0 0 0 5
# Load number wrap between store and load, then commit past the load
1 700 2 70 01 0 0  0 0 0 0 0 0 0  7e 0 0 0  0 0 0 0 5
2 702 0 6e 7f 5000 0  0 0 0 0 0 0 0  7e 0 0 0  1 5004 6e 7f 5
0 0 0 0 0 0 0  0 0 0 0 0 0 0  2 0 0 0  0 0 0 0 9
2 702 0 6f 7f 5010 0  0 0 0 0 0 0 0  2 0 0 0  0 0 0 0 9
0 0 0 0 0 0 0  0 0 0 0 0 0 0  2 0 0 0  0 0 0 0 9

// File: flist.f
src/lbPkg.sv
src/loadEntryArray.sv
src/orderChecker.sv
src/rollbackArbiter.sv
src/loadBuffer.sv
dv/loadBufferTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module loadBufferTb \
    -f flist.f -Mdir obj_dir -o loadBufferSim || exit 1
simOutput=$(./obj_dir/loadBufferSim 2>&1)
printf '%s\n' "$simOutput"
printf '%s\n' "$simOutput" | grep -qx "No errors" && exit 0 || exit 1
